//--- hdl/gsharePkg.sv
// gshare predictor shared definitions
// Widths, counter constants, request/response/update structs and the
// PHT index hash used by the RTL and by the testbench model
`default_nettype none

package gsharePkg;

    localparam int FETCH_WIDTH_DEF = 2;
    localparam int ISSUE_WIDTH_DEF = 2;
    localparam int PHT_INDEX_W = 8;
    localparam int HISTORY_W = 4;
    localparam int PC_W = 32;
    localparam int COUNTER_W = 2;

    localparam int PHT_ENTRIES = 1 << PHT_INDEX_W;
    // Instructions are 4 bytes, the low PC bits never reach the index
    localparam int INSN_BYTES = 4;
    localparam int INSN_OFFSET_W = 2;

    typedef logic [PHT_INDEX_W-1:0] phtIndexT;
    typedef logic [HISTORY_W-1:0] historyT;
    typedef logic [PC_W-1:0] pcT;
    typedef logic [COUNTER_W-1:0] counterT;

    localparam counterT COUNTER_MAX = counterT'(3);
    localparam counterT COUNTER_INIT = counterT'(2);

    typedef struct packed {
        logic valid;
        pcT pc;
        logic [FETCH_WIDTH_DEF-1:0] btbHit;
        logic [FETCH_WIDTH_DEF-1:0] isCondBr;
    } lookupReqT;

    typedef struct packed {
        logic valid;
        logic [FETCH_WIDTH_DEF-1:0] predTaken;
        phtIndexT [FETCH_WIDTH_DEF-1:0] phtIndex;
        counterT [FETCH_WIDTH_DEF-1:0] prevCounter;
        historyT history;
    } lookupRespT;

    typedef struct packed {
        logic valid;
        phtIndexT phtIndex;
        counterT prevCounter;
        logic taken;
        logic mispred;
    } resolveT;

    typedef struct packed {
        logic valid;
        phtIndexT index;
        counterT counter;
    } phtWriteT;

    // PC bits above the instruction offset, history folded in from the top bit down
    function automatic phtIndexT phtIndexOf(input pcT pc, input historyT history);
        phtIndexT idx;
        idx = pc[PHT_INDEX_W+INSN_OFFSET_W-1:INSN_OFFSET_W];
        for (int i = 0; i < HISTORY_W; i++) begin
            idx[PHT_INDEX_W-1-i] = idx[PHT_INDEX_W-1-i] ^ history[i];
        end
        return idx;
    endfunction

    // Bank of an index in a PHT split into the given number of banks
    function automatic int bankOf(input phtIndexT idx, input int banks);
        return int'(idx) % banks;
    endfunction

endpackage

`default_nettype wire

//--- hdl/phtBankRam.sv
// Banked pattern history table
// fetchWidth registered read ports, issueWidth write ports routed to the
// bank each one addresses; reads return old data on a same-cycle write
`timescale 1ns/1ps
`default_nettype none

module phtBankRam #(
    parameter int fetchWidth = gsharePkg::FETCH_WIDTH_DEF,
    parameter int issueWidth = gsharePkg::ISSUE_WIDTH_DEF
) (
    input  wire                      clk,
    input  wire gsharePkg::phtIndexT raddr [fetchWidth],
    output gsharePkg::counterT       rdata [fetchWidth],
    input  wire gsharePkg::phtWriteT wr [issueWidth]
);

    localparam int BANK_DEPTH = gsharePkg::PHT_ENTRIES / issueWidth;

    wire gsharePkg::counterT bankRd [issueWidth][fetchWidth];
    int bankSel [fetchWidth];

    for (genvar b = 0; b < issueWidth; b++) begin : gBank
        gsharePkg::counterT mem [BANK_DEPTH];
        gsharePkg::counterT rdReg [fetchWidth];

        always_ff @(posedge clk) begin
            // At most one port targets this bank in a cycle
            for (int p = 0; p < issueWidth; p++) begin
                if (wr[p].valid && gsharePkg::bankOf(wr[p].index, issueWidth) == b) begin
                    mem[int'(wr[p].index) / issueWidth] <= wr[p].counter;
                end
            end
            for (int r = 0; r < fetchWidth; r++) begin
                rdReg[r] <= mem[int'(raddr[r]) / issueWidth];
            end
        end

        assign bankRd[b] = rdReg;
    end

    // Remember which bank each read port went to
    always_ff @(posedge clk) begin
        for (int r = 0; r < fetchWidth; r++) begin
            bankSel[r] <= gsharePkg::bankOf(raddr[r], issueWidth);
        end
    end

    always_comb begin
        for (int r = 0; r < fetchWidth; r++) begin
            rdata[r] = bankRd[bankSel[r]][r];
        end
    end

endmodule

`default_nettype wire

//--- hdl/phtWriteQueue.sv
// Write queue for PHT bank conflicts
// Circular FIFO of any payload type, pushes while full are lost
`timescale 1ns/1ps
`default_nettype none

module phtWriteQueue #(
    parameter int  depth  = 4,
    parameter type entryT = logic
) (
    input  wire        clk,
    input  wire        rstN,
    input  wire        push,
    input  wire entryT pushData,
    input  wire        pop,
    output entryT      head,
    output logic       full,
    output logic       empty
);

    localparam int PTR_W = (depth > 1) ? $clog2(depth) : 1;
    localparam int CNT_W = $clog2(depth + 1);

    entryT mem [depth];
    logic [PTR_W-1:0] headPtr;
    logic [PTR_W-1:0] tailPtr;
    logic [CNT_W-1:0] count;
    logic doPush;
    logic doPop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == CNT_W'(depth));
    assign empty = (count == '0);
    assign doPush = push && !full;
    assign doPop = pop && !empty;
    assign head = mem[headPtr];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) tailPtr <= nextPtr(tailPtr);
            if (doPop) headPtr <= nextPtr(headPtr);
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) mem[tailPtr] <= pushData;
    end

endmodule

`default_nettype wire

//--- hdl/phtUpdateArbiter.sv
// PHT update arbiter
// Saturating counter updates from resolved branches, bank conflict
// diversion into the write queue, replay on idle ports, reset fill
`timescale 1ns/1ps
`default_nettype none

module phtUpdateArbiter #(
    parameter int issueWidth = gsharePkg::ISSUE_WIDTH_DEF,
    parameter int queueDepth = 4
) (
    input  wire                      clk,
    input  wire                      rstN,
    input  wire gsharePkg::resolveT  resolve [issueWidth],
    output gsharePkg::phtWriteT      wr [issueWidth],
    output logic                     qPush,
    output gsharePkg::phtWriteT      qPushData,
    output logic                     qPop,
    input  wire gsharePkg::phtWriteT qHead,
    input  wire                      qFull,
    input  wire                      qEmpty,
    output logic                     mispredSeen,
    output logic                     ready
);

    localparam gsharePkg::phtIndexT LAST_FILL =
        gsharePkg::PHT_INDEX_W'(gsharePkg::PHT_ENTRIES - issueWidth);

    if (queueDepth < 1 || (gsharePkg::PHT_ENTRIES % issueWidth) != 0) begin : gCfgCheck
        $error("Unsupported PHT queue depth or bank count");
    end

    gsharePkg::phtIndexT fillIndex;

    function automatic gsharePkg::counterT satUpdate(input gsharePkg::counterT prev,
                                                     input logic taken);
        if (taken) begin
            return (prev == gsharePkg::COUNTER_MAX) ? prev : prev + 1'b1;
        end
        return (prev == '0) ? prev : prev - 1'b1;
    endfunction

    always_comb begin
        logic headBlocked;
        logic placed;
        qPush = 1'b0;
        qPushData = '0;
        qPop = 1'b0;
        mispredSeen = 1'b0;
        headBlocked = 1'b0;
        placed = 1'b0;

        for (int i = 0; i < issueWidth; i++) begin
            wr[i].valid = ready && resolve[i].valid;
            wr[i].index = resolve[i].phtIndex;
            wr[i].counter = satUpdate(resolve[i].prevCounter, resolve[i].taken);
            if (wr[i].valid && resolve[i].mispred) mispredSeen = 1'b1;
        end

        // A later slot on an earlier slot's bank goes to the queue
        for (int i = 1; i < issueWidth; i++) begin
            for (int j = 0; j < i; j++) begin
                if (wr[i].valid && wr[j].valid &&
                    gsharePkg::bankOf(wr[i].index, issueWidth) ==
                    gsharePkg::bankOf(wr[j].index, issueWidth)) begin
                    if (!qPush) begin
                        qPush = 1'b1;
                        qPushData = wr[i];
                    end
                    wr[i].valid = 1'b0;
                end
            end
        end

        // Head waits while any active write uses its bank
        for (int j = 0; j < issueWidth; j++) begin
            if (wr[j].valid && gsharePkg::bankOf(qHead.index, issueWidth) ==
                gsharePkg::bankOf(wr[j].index, issueWidth)) begin
                headBlocked = 1'b1;
            end
        end
        if (!qEmpty && !headBlocked) begin
            for (int i = 0; i < issueWidth; i++) begin
                if (!placed && !wr[i].valid) begin
                    wr[i] = qHead;
                    wr[i].valid = 1'b1;
                    qPop = 1'b1;
                    placed = 1'b1;
                end
            end
        end

        // Fill owns every write port until the table is initialized
        if (!ready) begin
            for (int i = 0; i < issueWidth; i++) begin
                wr[i].valid = 1'b1;
                wr[i].index = fillIndex + gsharePkg::PHT_INDEX_W'(i);
                wr[i].counter = gsharePkg::COUNTER_INIT;
            end
            qPush = 1'b0;
            qPop = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            fillIndex <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            fillIndex <= fillIndex + gsharePkg::PHT_INDEX_W'(issueWidth);
            if (fillIndex == LAST_FILL) ready <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hdl/gshareLookup.sv
// gshare lookup and global history
// Forms the PHT read indexes from PC and history, predicts per slot one
// cycle later, and keeps the speculative history with recovery
`timescale 1ns/1ps
`default_nettype none

module gshareLookup #(
    parameter int fetchWidth = gsharePkg::FETCH_WIDTH_DEF
) (
    input  wire                       clk,
    input  wire                       rstN,
    input  wire gsharePkg::lookupReqT lookupReq,
    output gsharePkg::phtIndexT       raddr [fetchWidth],
    input  wire gsharePkg::counterT   rdata [fetchWidth],
    input  wire                       mispredSeen,
    input  wire                       recoverValid,
    input  wire gsharePkg::historyT   recoverHistory,
    input  wire                       ready,
    output gsharePkg::lookupRespT     lookupResp
);

    localparam int HW = gsharePkg::HISTORY_W;

    // Control state
    logic respValidQ;
    logic mispredQ;
    gsharePkg::historyT historyQ;

    // Request held for the response cycle
    logic [fetchWidth-1:0] btbHitQ;
    logic [fetchWidth-1:0] isCondBrQ;
    gsharePkg::phtIndexT indexQ [fetchWidth];

    logic [fetchWidth-1:0] predTaken;
    gsharePkg::historyT shiftedHistory;
    gsharePkg::historyT nextHistory;

    // Per-slot direction and history shift for the response in flight
    always_comb begin
        logic groupEnded;
        groupEnded = 1'b0;
        shiftedHistory = historyQ;
        for (int i = 0; i < fetchWidth; i++) begin
            // Counter MSB set means taken, unconditional hits always are
            predTaken[i] = btbHitQ[i] &&
                (rdata[i][gsharePkg::COUNTER_W-1] || !isCondBrQ[i]);
            if (respValidQ && !mispredQ && !groupEnded &&
                btbHitQ[i] && isCondBrQ[i]) begin
                shiftedHistory = {shiftedHistory[HW-2:0], predTaken[i]};
            end
            // Nothing after a taken slot is fetched
            if (predTaken[i]) groupEnded = 1'b1;
        end
    end

    assign nextHistory = recoverValid ? recoverHistory : shiftedHistory;

    always_comb begin
        for (int i = 0; i < fetchWidth; i++) begin
            raddr[i] = gsharePkg::phtIndexOf(
                lookupReq.pc + gsharePkg::PC_W'(gsharePkg::INSN_BYTES * i),
                nextHistory
            );
        end
    end

    always_comb begin
        lookupResp = '0;
        lookupResp.valid = respValidQ;
        lookupResp.history = shiftedHistory;
        for (int i = 0; i < fetchWidth; i++) begin
            lookupResp.predTaken[i] = predTaken[i];
            lookupResp.phtIndex[i] = indexQ[i];
            lookupResp.prevCounter[i] = rdata[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            respValidQ <= 1'b0;
            mispredQ <= 1'b0;
            historyQ <= '0;
        end else begin
            // Requests during the fill are dropped
            respValidQ <= lookupReq.valid && ready;
            mispredQ <= mispredSeen;
            historyQ <= nextHistory;
        end
    end

    always_ff @(posedge clk) begin
        btbHitQ <= lookupReq.btbHit[fetchWidth-1:0];
        isCondBrQ <= lookupReq.isCondBr[fetchWidth-1:0];
        indexQ <= raddr;
    end

endmodule

`default_nettype wire

//--- hdl/branchPredictorTop.sv
// gshare branch predictor top level
// Update arbiter, conflict write queue, banked PHT and lookup logic
`timescale 1ns/1ps
`default_nettype none

module branchPredictorTop #(
    parameter int fetchWidth = gsharePkg::FETCH_WIDTH_DEF,
    parameter int issueWidth = gsharePkg::ISSUE_WIDTH_DEF,
    parameter int queueDepth = 4
) (
    input  wire                       clk,
    input  wire                       rstN,
    input  wire gsharePkg::lookupReqT lookupReq,
    input  wire gsharePkg::resolveT   resolve [issueWidth],
    input  wire                       recoverValid,
    input  wire gsharePkg::historyT   recoverHistory,
    output gsharePkg::lookupRespT     lookupResp,
    output logic                      ready
);

    gsharePkg::phtIndexT raddr [fetchWidth];
    gsharePkg::counterT rdata [fetchWidth];
    gsharePkg::phtWriteT wr [issueWidth];
    gsharePkg::phtWriteT qPushData;
    gsharePkg::phtWriteT qHead;
    logic qPush;
    logic qPop;
    logic qFull;
    logic qEmpty;
    logic mispredSeen;

    phtUpdateArbiter #(.issueWidth(issueWidth), .queueDepth(queueDepth)) i_phtUpdateArbiter (
        .clk(clk), .rstN(rstN), .resolve(resolve), .wr(wr),
        .qPush(qPush), .qPushData(qPushData), .qPop(qPop), .qHead(qHead),
        .qFull(qFull), .qEmpty(qEmpty), .mispredSeen(mispredSeen), .ready(ready)
    );

    phtWriteQueue #(.depth(queueDepth), .entryT(gsharePkg::phtWriteT)) i_phtWriteQueue (
        .clk(clk), .rstN(rstN), .push(qPush), .pushData(qPushData),
        .pop(qPop), .head(qHead), .full(qFull), .empty(qEmpty)
    );

    phtBankRam #(.fetchWidth(fetchWidth), .issueWidth(issueWidth)) i_phtBankRam (
        .clk(clk), .raddr(raddr), .rdata(rdata), .wr(wr)
    );

    gshareLookup #(.fetchWidth(fetchWidth)) i_gshareLookup (
        .clk(clk), .rstN(rstN), .lookupReq(lookupReq), .raddr(raddr), .rdata(rdata),
        .mispredSeen(mispredSeen), .recoverValid(recoverValid),
        .recoverHistory(recoverHistory), .ready(ready), .lookupResp(lookupResp)
    );

endmodule

`default_nettype wire

//--- verification/clockGen.sv
// Testbench clock and reset source
// Free running clock, active low reset released after a few rising edges
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Release lands 1 ns after an edge, like the rest of the stimulus
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1;
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/gshareChecks_asserts.sv
// Bound checks on the gshare predictor top level
// Fill gating, lookup timing, queue overflow and write port banks
`timescale 1ns/1ps
`default_nettype none

module gshareChecks #(
    parameter int issueWidth = gsharePkg::ISSUE_WIDTH_DEF
) (
    input wire                        clk,
    input wire                        rstN,
    input wire gsharePkg::lookupReqT  lookupReq,
    input wire gsharePkg::lookupRespT lookupResp,
    input wire                        ready,
    input wire                        qPush,
    input wire                        qFull,
    input wire gsharePkg::phtWriteT   wr [issueWidth]
);

    logic bankClash;

    // Two active write ports on one bank
    always_comb begin
        bankClash = 1'b0;
        for (int i = 0; i < issueWidth; i++) begin
            for (int j = i + 1; j < issueWidth; j++) begin
                if (wr[i].valid && wr[j].valid &&
                    gsharePkg::bankOf(wr[i].index, issueWidth) ==
                    gsharePkg::bankOf(wr[j].index, issueWidth)) begin
                    bankClash = 1'b1;
                end
            end
        end
    end

    respAfterReady: assert property (@(posedge clk) disable iff (!rstN)
        lookupResp.valid |-> ready)
        else $error("lookup response before the PHT fill completed");

    reqGivesResp: assert property (@(posedge clk) disable iff (!rstN)
        lookupReq.valid && ready |=> lookupResp.valid)
        else $error("accepted lookup request without a response one cycle later");

    respHasReq: assert property (@(posedge clk) disable iff (!rstN)
        lookupResp.valid |-> $past(lookupReq.valid && ready))
        else $error("lookup response without a request in the previous cycle");

    noPushWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        !(qPush && qFull))
        else $error("bank conflict write dropped, write queue full");

    oneWritePerBank: assert property (@(posedge clk) disable iff (!rstN)
        !bankClash)
        else $error("two PHT write ports target the same bank");

endmodule

`default_nettype wire

//--- verification/tbBranchPredictor.sv
// Testbench for the gshare branch predictor
// Directed tests against a counter and history model built from the
// predictor rules: fill, slot rules, saturation, bank conflicts, recovery
`timescale 1ns/1ps
`default_nettype none

module tbBranchPredictor;

    localparam int FW = gsharePkg::FETCH_WIDTH_DEF;
    localparam int IW = gsharePkg::ISSUE_WIDTH_DEF;
    localparam int FILL_CYCLES = gsharePkg::PHT_ENTRIES / IW;
    // Reset plus the cycles each directed test spends in turn
    localparam int TEST_CYCLES = 4 + 2 + 6 + 11 + 4 + 3 + 1;
    localparam int TIMEOUT_CYCLES = FILL_CYCLES + TEST_CYCLES + 2000;
    localparam logic [31:0] SEED = 32'h980f_a857;

    logic clk;
    logic rstN;
    gsharePkg::lookupReqT lookupReq;
    gsharePkg::resolveT resolve [IW];
    logic recoverValid;
    gsharePkg::historyT recoverHistory;
    gsharePkg::lookupRespT lookupResp;
    logic ready;

    // Reference model state
    gsharePkg::counterT modelPht [gsharePkg::PHT_ENTRIES];
    gsharePkg::historyT modelHist;
    int checkCount = 0;
    int errorCount = 0;
    int cycleCount = 0;

    clockGen #(.periodNs(8), .resetCycles(4)) i_clockGen (.clk(clk), .rstN(rstN));

    branchPredictorTop #(.fetchWidth(FW), .issueWidth(IW), .queueDepth(4)) i_branchPredictorTop (
        .clk(clk), .rstN(rstN), .lookupReq(lookupReq), .resolve(resolve),
        .recoverValid(recoverValid), .recoverHistory(recoverHistory),
        .lookupResp(lookupResp), .ready(ready)
    );

    bind branchPredictorTop gshareChecks #(.issueWidth(issueWidth)) i_gshareChecks (
        .clk(clk), .rstN(rstN), .lookupReq(lookupReq), .lookupResp(lookupResp),
        .ready(ready), .qPush(qPush), .qFull(qFull), .wr(wr)
    );

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic compareValue(input logic [31:0] got, input logic [31:0] expected,
                                input string what);
        checkCount++;
        if (got !== expected) begin
            errorCount++;
            $display("ERR %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, expected);
        end
    endtask

    // 2-bit counter, one step toward the outcome, held at both ends
    function automatic gsharePkg::counterT saturatedCounter(input gsharePkg::counterT prev,
                                                            input logic taken);
        if (taken && prev != gsharePkg::COUNTER_MAX) return prev + 1'b1;
        if (!taken && prev != '0) return prev - 1'b1;
        return prev;
    endfunction

    function automatic gsharePkg::pcT randomPc();
        return gsharePkg::pcT'($urandom()) & ~gsharePkg::pcT'(3);
    endfunction

    task automatic driveResolve(input int slot, input gsharePkg::phtIndexT idx,
                                input logic taken, input logic mispred);
        resolve[slot].valid = 1'b1;
        resolve[slot].phtIndex = idx;
        resolve[slot].prevCounter = modelPht[idx];
        resolve[slot].taken = taken;
        resolve[slot].mispred = mispred;
    endtask

    // One clock; resolves driven in it reach the model, inputs return to idle
    task automatic advanceCycle();
        @(posedge clk);
        #1;
        for (int s = 0; s < IW; s++) begin
            if (resolve[s].valid) begin
                modelPht[resolve[s].phtIndex] =
                    saturatedCounter(resolve[s].prevCounter, resolve[s].taken);
            end
            resolve[s] = '0;
        end
        lookupReq = '0;
        recoverValid = 1'b0;
    endtask

    task automatic lookupAndCompare(input gsharePkg::pcT pc, input logic [FW-1:0] hit,
                                    input logic [FW-1:0] cond, input logic frozen);
        gsharePkg::phtIndexT idx [FW];
        gsharePkg::counterT cnt [FW];
        logic taken;
        logic ended;
        ended = 1'b0;
        lookupReq.valid = 1'b1;
        lookupReq.pc = pc;
        lookupReq.btbHit = hit;
        lookupReq.isCondBr = cond;
        // Reads see the table as it was before this cycle's writes
        for (int i = 0; i < FW; i++) begin
            idx[i] = gsharePkg::phtIndexOf(pc + gsharePkg::PC_W'(gsharePkg::INSN_BYTES * i),
                                           modelHist);
            cnt[i] = modelPht[idx[i]];
        end
        advanceCycle();
        compareValue(lookupResp.valid, 1'b1, "response valid one cycle after request");
        for (int i = 0; i < FW; i++) begin
            taken = hit[i] && (cnt[i][gsharePkg::COUNTER_W-1] || !cond[i]);
            compareValue(lookupResp.phtIndex[i], idx[i], $sformatf("slot %0d phtIndex", i));
            compareValue(lookupResp.prevCounter[i], cnt[i], $sformatf("slot %0d counter", i));
            compareValue(lookupResp.predTaken[i], taken, $sformatf("slot %0d predTaken", i));
            if (!frozen && !ended && hit[i] && cond[i]) begin
                modelHist = {modelHist[gsharePkg::HISTORY_W-2:0], taken};
            end
            if (taken) ended = 1'b1;
        end
        compareValue(lookupResp.history, modelHist, "returned history");
    endtask

    task automatic fillAndFirstLookups();
        int fillCycles;
        fillCycles = 0;
        wait (rstN === 1'b1);
        // Requests issued during the fill get no response
        lookupReq.valid = 1'b1;
        lookupReq.pc = randomPc();
        lookupReq.btbHit = '1;
        lookupReq.isCondBr = '1;
        while (ready !== 1'b1) begin
            @(posedge clk);
            #1;
            fillCycles++;
            compareValue(lookupResp.valid, 1'b0, "no response during fill");
        end
        compareValue(fillCycles, FILL_CYCLES, "cycles from reset release to ready");
        lookupAndCompare(randomPc(), 2'b11, 2'b11, 1'b0);
        compareValue(lookupResp.prevCounter[0], gsharePkg::COUNTER_INIT, "counter after fill");
        lookupAndCompare(randomPc(), 2'b10, 2'b10, 1'b0);
    endtask

    task automatic slotRules();
        logic [3:0] patterns [6];
        // Upper pair is btbHit, lower pair isCondBr
        patterns = '{4'b00_11, 4'b01_00, 4'b10_10, 4'b11_11, 4'b01_01, 4'b11_10};
        for (int k = 0; k < 6; k++) begin
            lookupAndCompare(randomPc(), patterns[k][3:2], patterns[k][1:0], 1'b0);
        end
    endtask

    task automatic saturation();
        gsharePkg::pcT pc;
        gsharePkg::phtIndexT idx;
        pc = randomPc();
        idx = gsharePkg::phtIndexOf(pc, modelHist);
        repeat (4) begin
            driveResolve(0, idx, 1'b0, 1'b0);
            advanceCycle();
        end
        lookupAndCompare(pc, 2'b01, 2'b01, 1'b0);
        compareValue(lookupResp.prevCounter[0], 0, "counter floor after not-taken run");
        idx = gsharePkg::phtIndexOf(pc, modelHist);
        repeat (5) begin
            driveResolve(0, idx, 1'b1, 1'b0);
            advanceCycle();
        end
        lookupAndCompare(pc, 2'b01, 2'b01, 1'b0);
        compareValue(lookupResp.prevCounter[0], gsharePkg::COUNTER_MAX, "counter ceiling");
    endtask

    task automatic bankConflict();
        gsharePkg::pcT pc;
        gsharePkg::phtIndexT idxA;
        gsharePkg::phtIndexT idxB;
        pc = randomPc();
        idxA = gsharePkg::phtIndexOf(pc, modelHist);
        // Flipping index bit 1 keeps the bank, the matching PC bit is 3
        idxB = idxA ^ gsharePkg::phtIndexT'(2);
        driveResolve(0, idxA, 1'b0, 1'b0);
        driveResolve(1, idxB, 1'b1, 1'b0);
        advanceCycle();
        compareValue(i_branchPredictorTop.qEmpty, 1'b0, "conflicting write queued");
        while (!i_branchPredictorTop.qEmpty) advanceCycle();
        lookupAndCompare(pc, 2'b00, 2'b00, 1'b0);
        lookupAndCompare(pc ^ gsharePkg::pcT'(8), 2'b00, 2'b00, 1'b0);
    endtask

    task automatic historyRecovery();
        // Alternating pattern, so any shift would show
        modelHist = 4'b0101;
        recoverValid = 1'b1;
        recoverHistory = modelHist;
        lookupAndCompare(randomPc(), 2'b00, 2'b00, 1'b0);
        driveResolve(0, gsharePkg::phtIndexT'($urandom()), 1'b1, 1'b1);
        lookupAndCompare(randomPc(), 2'b11, 2'b11, 1'b1);
        modelHist = gsharePkg::historyT'($urandom());
        recoverValid = 1'b1;
        recoverHistory = modelHist;
        lookupAndCompare(randomPc(), 2'b11, 2'b01, 1'b0);
    endtask

    initial begin
        lookupReq = '0;
        for (int s = 0; s < IW; s++) resolve[s] = '0;
        recoverValid = 1'b0;
        recoverHistory = '0;
        modelHist = '0;
        for (int i = 0; i < gsharePkg::PHT_ENTRIES; i++) modelPht[i] = gsharePkg::COUNTER_INIT;
        void'($urandom(SEED));

        fillAndFirstLookups();
        slotRules();
        saturation();
        bankConflict();
        historyRecovery();
        advanceCycle();

        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hdl/gsharePkg.sv
hdl/phtBankRam.sv
hdl/phtWriteQueue.sv
hdl/phtUpdateArbiter.sv
hdl/gshareLookup.sv
hdl/branchPredictorTop.sv
verification/clockGen.sv
verification/gshareChecks_asserts.sv
verification/tbBranchPredictor.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the gshare predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module tbBranchPredictor -Mdir obj_dir -o simv

./obj_dir/simv | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
